/* tomasulo_pkg.sv */
`default_nettype none

package tomasulo_pkg;

	// --------------------------------------------------
	// Core dimensions
	// --------------------------------------------------
	localparam int XLEN       = 32;   // Data path width
	localparam int REG_ADDR_W = 5;    // Architectural register index
	localparam int NUM_REGS   = 32;   // x0..x31
	localparam int NUM_RS     = 4;    // ALU reservation stations
	localparam int TAG_W      = 3;    // Tag 0 means value present
	localparam int ALU_OP_W   = 4;    // {alt bit, funct3}

	// --------------------------------------------------
	// ALU operation codes
	// --------------------------------------------------
	localparam logic [ALU_OP_W-1:0] OP_ADD  = 4'b0000;
	localparam logic [ALU_OP_W-1:0] OP_SUB  = 4'b1000;   // Alt form of ADD
	localparam logic [ALU_OP_W-1:0] OP_SLL  = 4'b0001;
	localparam logic [ALU_OP_W-1:0] OP_SLT  = 4'b0010;   // Signed compare
	localparam logic [ALU_OP_W-1:0] OP_SLTU = 4'b0011;   // Unsigned compare
	localparam logic [ALU_OP_W-1:0] OP_XOR  = 4'b0100;
	localparam logic [ALU_OP_W-1:0] OP_SRL  = 4'b0101;
	localparam logic [ALU_OP_W-1:0] OP_SRA  = 4'b1101;   // Alt form of SRL
	localparam logic [ALU_OP_W-1:0] OP_OR   = 4'b0110;
	localparam logic [ALU_OP_W-1:0] OP_AND  = 4'b0111;

	// RV32I major opcodes handled here
	localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate

	// --------------------------------------------------
	// Instruction word, R and I views of the same bits
	// --------------------------------------------------
	typedef union packed {
		struct packed {
			logic [6:0]            funct7;   // Bit 5 picks SUB / SRA
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} r;
		struct packed {
			logic [11:0]           imm12;    // Sign bit at 11
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} i;
	} inst_word_u;

endpackage

`default_nettype wire

/* alu_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_issue (
	input  logic                                inst_valid,
	input  tomasulo_pkg::inst_word_u            inst,
	input  logic                                all_busy,
	input  logic [tomasulo_pkg::TAG_W-1:0]      free_tag,
	input  logic [tomasulo_pkg::TAG_W-1:0]      rs1_tag,
	input  logic [tomasulo_pkg::TAG_W-1:0]      rs2_tag,
	input  logic [tomasulo_pkg::XLEN-1:0]       rs1_value,
	input  logic [tomasulo_pkg::XLEN-1:0]       rs2_value,
	output logic                                issue_stall,
	output logic [tomasulo_pkg::REG_ADDR_W-1:0] rs1_addr,
	output logic [tomasulo_pkg::REG_ADDR_W-1:0] rs2_addr,
	output logic [tomasulo_pkg::REG_ADDR_W-1:0] rd_addr,
	output logic                                rename_en,
	output logic                                issue,
	output logic [tomasulo_pkg::ALU_OP_W-1:0]   issue_op,
	output logic [tomasulo_pkg::TAG_W-1:0]      q1,
	output logic [tomasulo_pkg::XLEN-1:0]       v1,
	output logic [tomasulo_pkg::TAG_W-1:0]      q2,
	output logic [tomasulo_pkg::XLEN-1:0]       v2
);
	import tomasulo_pkg::*;

	logic            is_reg;     // OP major opcode
	logic            is_imm;     // OP-IMM major opcode
	logic            is_shift;   // funct3 001 or 101
	logic            has_free;   // Station pool can take one more
	logic            alt;        // SUB / SRA / SRAI
	logic [XLEN-1:0] imm;        // Operand 2 for OP-IMM

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------
	assign is_reg   = (inst.r.opcode == OPC_OP);
	assign is_imm   = (inst.i.opcode == OPC_OP_IMM);
	assign is_shift = (inst.i.funct3[1:0] == 2'b01);
	assign has_free = (free_tag != '0);

	always_comb begin
		alt = 1'b0;
		if (is_reg)
			alt = inst.r.funct7[5] & (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101);
		else if (is_imm)
			alt = inst.i.imm12[10] & (inst.i.funct3 == 3'b101);  // No SUBI in RV32I
	end

	assign issue_op = {alt, inst.r.funct3};

	// Shift amount is only imm[4:0]
	assign imm = is_shift ? {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]}
	                      : {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

	// Register file lookup
	assign rs1_addr = inst.i.rs1;
	assign rs2_addr = inst.r.rs2;
	assign rd_addr  = inst.r.rd;

	// --------------------------------------------------
	// Issue and rename
	// --------------------------------------------------
	assign issue_stall = all_busy;
	assign issue       = inst_valid & has_free & (is_reg | is_imm);
	assign rename_en   = issue;      // Regfile drops x0 renames

	assign q1 = rs1_tag;
	assign v1 = rs1_value;
	assign q2 = is_imm ? '0 : rs2_tag;      // Immediate is always present
	assign v2 = is_imm ? imm : rs2_value;

	// Station pool must agree that a free tag means not all busy
	always_comb begin
		assert (!(issue && all_busy))
			else $error("alu_issue: issue while all stations busy");
	end

endmodule

`default_nettype wire

/* tagged_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tagged_regfile (
	input  logic                                          debug_clk,
	input  logic                                          rst,
	input  logic [tomasulo_pkg::REG_ADDR_W-1:0]           rs1_addr,
	input  logic [tomasulo_pkg::REG_ADDR_W-1:0]           rs2_addr,
	input  logic [tomasulo_pkg::REG_ADDR_W-1:0]           rd_addr,
	input  logic                                          rename_en,
	input  logic [tomasulo_pkg::TAG_W-1:0]                rename_tag,
	input  logic                                          cdb_valid,
	input  logic [tomasulo_pkg::TAG_W-1:0]                cdb_tag,
	input  logic [tomasulo_pkg::XLEN-1:0]                 cdb_value,
	input  logic [tomasulo_pkg::REG_ADDR_W-1:0]           debug_addr,
	output logic [tomasulo_pkg::TAG_W-1:0]                rs1_tag,
	output logic [tomasulo_pkg::XLEN-1:0]                 rs1_value,
	output logic [tomasulo_pkg::TAG_W-1:0]                rs2_tag,
	output logic [tomasulo_pkg::XLEN-1:0]                 rs2_value,
	output logic [tomasulo_pkg::TAG_W+tomasulo_pkg::XLEN-1:0] debug_data
);
	import tomasulo_pkg::*;

	logic [XLEN-1:0]  reg_value [NUM_REGS];   // Architectural value
	logic [TAG_W-1:0] reg_tag   [NUM_REGS];   // Pending producer, 0 if none

	// True when tag is pending and its result is on the CDB now
	function automatic logic cdb_hit(input logic [TAG_W-1:0] tag);
		return cdb_valid && tag != '0 && tag == cdb_tag;
	endfunction

	// --------------------------------------------------
	// Read ports with CDB bypass
	// --------------------------------------------------
	always_comb begin
		rs1_tag   = reg_tag[rs1_addr];
		rs1_value = reg_value[rs1_addr];
		if (cdb_hit(reg_tag[rs1_addr])) begin
			rs1_tag   = '0;           // Result arriving this cycle
			rs1_value = cdb_value;
		end
	end

	always_comb begin
		rs2_tag   = reg_tag[rs2_addr];
		rs2_value = reg_value[rs2_addr];
		if (cdb_hit(reg_tag[rs2_addr])) begin
			rs2_tag   = '0;
			rs2_value = cdb_value;
		end
	end

	// Raw view, no bypass
	assign debug_data = {reg_tag[debug_addr], reg_value[debug_addr]};

	// --------------------------------------------------
	// Rename and CDB writeback
	// --------------------------------------------------
	always_ff @(posedge debug_clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				reg_tag[i]   <= '0;
				reg_value[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (rename_en && rd_addr != '0 && rd_addr == REG_ADDR_W'(i))   // x0 is never renamed
					reg_tag[i] <= rename_tag;             // Newest producer wins
				else if (cdb_hit(reg_tag[i])) begin
					reg_tag[i]   <= '0;
					reg_value[i] <= cdb_value;
				end
			end
		end
	end

	// x0 must never wait on a station
	a_x0_no_tag: assert property (@(posedge debug_clk) disable iff (rst)
		reg_tag[0] == '0)
		else $error("tagged_regfile: x0 carries a tag");

endmodule

`default_nettype wire

/* alu_station.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_station (
	input  logic                              debug_clk,
	input  logic                              rst,
	input  logic                              issue,
	input  logic [tomasulo_pkg::ALU_OP_W-1:0] issue_op,
	input  logic [tomasulo_pkg::TAG_W-1:0]    q1,
	input  logic [tomasulo_pkg::XLEN-1:0]     v1,
	input  logic [tomasulo_pkg::TAG_W-1:0]    q2,
	input  logic [tomasulo_pkg::XLEN-1:0]     v2,
	input  logic                              cdb_valid,
	input  logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
	input  logic [tomasulo_pkg::XLEN-1:0]     cdb_value,
	output logic                              all_busy,
	output logic [tomasulo_pkg::TAG_W-1:0]    free_tag,
	output logic                              dispatch,
	output logic [tomasulo_pkg::ALU_OP_W-1:0] dispatch_op,
	output logic [tomasulo_pkg::TAG_W-1:0]    dispatch_tag,
	output logic [tomasulo_pkg::XLEN-1:0]     dispatch_a,
	output logic [tomasulo_pkg::XLEN-1:0]     dispatch_b
);
	import tomasulo_pkg::*;

	logic [NUM_RS-1:0]   busy;            // Entry holds an instruction
	logic [NUM_RS-1:0]   disp;            // Sent to ALU, result not yet out
	logic [NUM_RS-1:0]   ready;           // Both operands present
	logic [ALU_OP_W-1:0] ent_op [NUM_RS];
	logic [TAG_W-1:0]    ent_q1 [NUM_RS];
	logic [XLEN-1:0]     ent_v1 [NUM_RS];
	logic [TAG_W-1:0]    ent_q2 [NUM_RS];
	logic [XLEN-1:0]     ent_v2 [NUM_RS];

	function automatic logic cdb_hit(input logic [TAG_W-1:0] tag);
		return cdb_valid && tag != '0 && tag == cdb_tag;
	endfunction

	// --------------------------------------------------
	// Allocation
	// --------------------------------------------------
	assign all_busy = &busy;

	always_comb begin
		free_tag = '0;                          // None free
		for (int i = NUM_RS - 1; i >= 0; i--)   // Lowest index wins
			if (!busy[i])
				free_tag = TAG_W'(i + 1);
	end

	// --------------------------------------------------
	// Select
	// --------------------------------------------------
	always_comb begin
		for (int i = 0; i < NUM_RS; i++)
			ready[i] = busy[i] & ~disp[i] & (ent_q1[i] == '0) & (ent_q2[i] == '0);
	end

	assign dispatch = |ready;

	always_comb begin
		dispatch_tag = '0;
		dispatch_op  = '0;
		dispatch_a   = '0;
		dispatch_b   = '0;
		for (int i = NUM_RS - 1; i >= 0; i--) begin
			if (ready[i]) begin
				dispatch_tag = TAG_W'(i + 1);
				dispatch_op  = ent_op[i];
				dispatch_a   = ent_v1[i];
				dispatch_b   = ent_v2[i];
			end
		end
	end

	// Entry state
	always_ff @(posedge debug_clk or posedge rst) begin
		if (rst) begin
			busy <= '0;
			disp <= '0;
		end else begin
			for (int i = 0; i < NUM_RS; i++) begin
				if (cdb_valid && busy[i] && cdb_tag == TAG_W'(i + 1)) begin
					busy[i] <= 1'b0;                  // Own result broadcast
					disp[i] <= 1'b0;
				end else if (issue && free_tag == TAG_W'(i + 1)) begin
					busy[i] <= 1'b1;
					disp[i] <= 1'b0;
				end else if (dispatch && dispatch_tag == TAG_W'(i + 1))
					disp[i] <= 1'b1;
			end
		end
	end

	// Operand capture, same-cycle CDB included
	always_ff @(posedge debug_clk) begin
		for (int i = 0; i < NUM_RS; i++) begin
			if (issue && free_tag == TAG_W'(i + 1)) begin
				ent_op[i] <= issue_op;
				ent_q1[i] <= cdb_hit(q1) ? '0 : q1;
				ent_v1[i] <= cdb_hit(q1) ? cdb_value : v1;
				ent_q2[i] <= cdb_hit(q2) ? '0 : q2;
				ent_v2[i] <= cdb_hit(q2) ? cdb_value : v2;
			end else begin
				if (cdb_hit(ent_q1[i])) begin
					ent_q1[i] <= '0;
					ent_v1[i] <= cdb_value;
				end
				if (cdb_hit(ent_q2[i])) begin
					ent_q2[i] <= '0;
					ent_v2[i] <= cdb_value;
				end
			end
		end
	end

	// Broadcast tag must belong to a busy entry already sent to the ALU
	a_cdb_owner: assert property (@(posedge debug_clk) disable iff (rst)
		cdb_valid |-> |(busy & disp & (NUM_RS'(1) << (cdb_tag - TAG_W'(1)))))
		else $error("alu_station: broadcast tag owns no dispatched entry");

endmodule

`default_nettype wire

/* alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
	input  logic                              debug_clk,
	input  logic                              rst,
	input  logic                              dispatch,
	input  logic [tomasulo_pkg::ALU_OP_W-1:0] dispatch_op,
	input  logic [tomasulo_pkg::TAG_W-1:0]    dispatch_tag,
	input  logic [tomasulo_pkg::XLEN-1:0]     dispatch_a,
	input  logic [tomasulo_pkg::XLEN-1:0]     dispatch_b,
	output logic                              cdb_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
	output logic [tomasulo_pkg::XLEN-1:0]     cdb_value
);
	import tomasulo_pkg::*;

	logic [XLEN-1:0] result;   // Combinational ALU output
	logic [4:0]      shamt;    // RV32 shift amount

	assign shamt = dispatch_b[4:0];

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	always_comb begin
		case (dispatch_op)
			OP_ADD:  result = dispatch_a + dispatch_b;
			OP_SUB:  result = dispatch_a - dispatch_b;
			OP_SLL:  result = dispatch_a << shamt;
			OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(dispatch_a) < $signed(dispatch_b)};
			OP_SLTU: result = {{(XLEN-1){1'b0}}, dispatch_a < dispatch_b};
			OP_XOR:  result = dispatch_a ^ dispatch_b;
			OP_SRL:  result = dispatch_a >> shamt;
			OP_SRA:  result = $unsigned($signed(dispatch_a) >>> shamt);  // Sign fill
			OP_OR:   result = dispatch_a | dispatch_b;
			OP_AND:  result = dispatch_a & dispatch_b;
			default: result = '0;
		endcase
	end

	// CDB drive, one pulse per dispatch
	always_ff @(posedge debug_clk or posedge rst) begin
		if (rst) begin
			cdb_valid <= 1'b0;
			cdb_tag   <= '0;
		end else begin
			cdb_valid <= dispatch;
			cdb_tag   <= dispatch_tag;
		end
	end

	always_ff @(posedge debug_clk) begin
		if (dispatch)
			cdb_value <= result;    // Held until next dispatch
	end

	a_cdb_tag: assert property (@(posedge debug_clk) disable iff (rst)
		cdb_valid |-> cdb_tag != '0)
		else $error("alu_exec: broadcast with tag 0");

endmodule

`default_nettype wire

/* tomasulo_alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tomasulo_alu_core (
	input  logic                                          debug_clk,
	input  logic                                          rst,
	input  logic                                          inst_valid,
	input  tomasulo_pkg::inst_word_u                      inst,
	input  logic [tomasulo_pkg::REG_ADDR_W-1:0]           debug_addr,
	output logic                                          issue_stall,
	output logic                                          cdb_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]                cdb_tag,
	output logic [tomasulo_pkg::XLEN-1:0]                 cdb_value,
	output logic [tomasulo_pkg::TAG_W+tomasulo_pkg::XLEN-1:0] debug_data
);
	import tomasulo_pkg::*;

	// --------------------------------------------------
	// Interconnect
	// --------------------------------------------------
	logic                  all_busy;       // Station pool full
	logic [TAG_W-1:0]      free_tag;       // Next station tag, also rename tag
	logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
	logic [TAG_W-1:0]      rs1_tag, rs2_tag;
	logic [XLEN-1:0]       rs1_value, rs2_value;
	logic                  rename_en;
	logic                  issue;
	logic [ALU_OP_W-1:0]   issue_op;
	logic [TAG_W-1:0]      q1, q2;
	logic [XLEN-1:0]       v1, v2;
	logic                  dispatch;
	logic [ALU_OP_W-1:0]   dispatch_op;
	logic [TAG_W-1:0]      dispatch_tag;
	logic [XLEN-1:0]       dispatch_a, dispatch_b;

	alu_issue issue0 (
		.inst_valid(inst_valid), .inst(inst), .all_busy(all_busy), .free_tag(free_tag),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.issue_stall(issue_stall), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rd_addr(rd_addr), .rename_en(rename_en), .issue(issue), .issue_op(issue_op),
		.q1(q1), .v1(v1), .q2(q2), .v2(v2)
	);

	tagged_regfile regs0 (
		.debug_clk(debug_clk), .rst(rst),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
		.rename_en(rename_en), .rename_tag(free_tag),   // Rename to allocated station
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.debug_addr(debug_addr),
		.rs1_tag(rs1_tag), .rs1_value(rs1_value), .rs2_tag(rs2_tag), .rs2_value(rs2_value),
		.debug_data(debug_data)
	);

	alu_station rs0 (
		.debug_clk(debug_clk), .rst(rst),
		.issue(issue), .issue_op(issue_op), .q1(q1), .v1(v1), .q2(q2), .v2(v2),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.all_busy(all_busy), .free_tag(free_tag),
		.dispatch(dispatch), .dispatch_op(dispatch_op), .dispatch_tag(dispatch_tag),
		.dispatch_a(dispatch_a), .dispatch_b(dispatch_b)
	);

	alu_exec exec0 (
		.debug_clk(debug_clk), .rst(rst),
		.dispatch(dispatch), .dispatch_op(dispatch_op), .dispatch_tag(dispatch_tag),
		.dispatch_a(dispatch_a), .dispatch_b(dispatch_b),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)   // Sole CDB source
	);

endmodule

`default_nettype wire

/* tb_tomasulo_alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_alu_core;
	import tomasulo_pkg::*;

	localparam int STALL_LIMIT = 100;   // Cycles one word may sit stalled
	localparam int DRAIN_LIMIT = 300;   // Cycles for all results to land

	logic                    debug_clk;
	logic                    rst;
	logic                    inst_valid;
	inst_word_u              inst;
	logic [REG_ADDR_W-1:0]   debug_addr;
	logic                    issue_stall;
	logic                    cdb_valid;
	logic [TAG_W-1:0]        cdb_tag;
	logic [XLEN-1:0]         cdb_value;
	logic [TAG_W+XLEN-1:0]   debug_data;

	int              seed = 32'h8881;
	inst_word_u      tab_inst [$];        // Stimulus words
	logic [XLEN-1:0] tab_exp  [$];        // Expected rd value per word
	logic [XLEN-1:0] pend_vals [$];       // Results not yet seen on the CDB
	logic [XLEN-1:0] model    [NUM_REGS]; // In-order architectural state
	int              exp_count;           // Supported words so far
	int              cdb_count;           // Broadcasts seen
	int              stall_count;         // Cycles with issue_stall high

	tomasulo_alu_core dut0 (
		.debug_clk(debug_clk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
		.debug_addr(debug_addr), .issue_stall(issue_stall), .cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag), .cdb_value(cdb_value), .debug_data(debug_data)
	);

	initial begin
		debug_clk = 1'b0;
		forever #4 debug_clk = ~debug_clk;   // 8 ns period
	end

	// --------------------------------------------------
	// Checks and failure exit
	// --------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_reg(input int idx, input logic [XLEN-1:0] got_v,
			input logic [TAG_W-1:0] got_t, input logic [XLEN-1:0] exp_v);
		if (got_t !== '0)
			stop_run($sformatf("mismatch at %0t: x%0d tag got %0d expected 0", $time, idx, got_t));
		if (got_v !== exp_v)
			stop_run($sformatf("mismatch at %0t: x%0d value got %h expected %h",
				$time, idx, got_v, exp_v));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// Completion order varies, so any outstanding result may match
	task automatic match_cdb_value(input logic [XLEN-1:0] got);
		int hit;
		hit = -1;
		foreach (pend_vals[k])
			if (hit < 0 && pend_vals[k] === got)
				hit = k;
		if (hit < 0)
			stop_run($sformatf("mismatch at %0t: cdb_value got %h, no pending result matches",
				$time, got));
		else
			pend_vals.delete(hit);
	endtask

	// Mid-cycle CDB and stall monitor
	always @(negedge debug_clk) begin
		if (!rst) begin
			if (issue_stall)
				stall_count++;
			if (cdb_valid) begin
				cdb_count++;
				if (cdb_tag == '0 || cdb_tag > TAG_W'(NUM_RS))
					stop_run($sformatf("CDB broadcast carried tag %0d outside 1..%0d at %0t",
						cdb_tag, NUM_RS, $time));
				else
					match_cdb_value(cdb_value);
			end
		end
	end

	// --------------------------------------------------
	// Reference model and table building
	// --------------------------------------------------
	function automatic logic is_alu(input inst_word_u w);
		return w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM;
	endfunction

	function automatic logic [XLEN-1:0] ref_result(input inst_word_u w,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] rb);
		logic [XLEN-1:0] b;
		logic [4:0]      sh;
		logic            alt;
		b   = (w.r.opcode == OPC_OP_IMM) ? {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12} : rb;
		sh  = b[4:0];                  // RV32 shifts use five bits
		alt = w.r.funct7[5];
		case (w.r.funct3)
			3'd0: return (alt && w.r.opcode == OPC_OP) ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
			3'd3: return XLEN'(a < b);
			3'd4: return a ^ b;
			3'd5: return alt ? (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh)) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic inst_word_u r_word(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		inst_word_u w;
		w.r.funct7 = f7;
		w.r.rs2    = REG_ADDR_W'(rs2);
		w.r.rs1    = REG_ADDR_W'(rs1);
		w.r.funct3 = f3;
		w.r.rd     = REG_ADDR_W'(rd);
		w.r.opcode = OPC_OP;
		return w;
	endfunction

	function automatic inst_word_u i_word(input logic [11:0] imm, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] opc);
		inst_word_u w;
		w.i.imm12  = imm;
		w.i.rs1    = REG_ADDR_W'(rs1);
		w.i.funct3 = f3;
		w.i.rd     = REG_ADDR_W'(rd);
		w.i.opcode = opc;
		return w;
	endfunction

	function automatic int pick_src();
		return ($random(seed) & 7) + 1;   // One of the loaded x1..x8
	endfunction

	function automatic logic [11:0] rnd12();
		logic [31:0] r;
		r = $random(seed);
		return r[11:0];
	endfunction

	// Run one word through the model and append it
	task automatic add_entry(input inst_word_u w);
		logic [XLEN-1:0] res;
		res = model[w.r.rd];             // Unsupported words change nothing
		if (is_alu(w)) begin
			res = ref_result(w, model[w.r.rs1], model[w.r.rs2]);
			if (w.r.rd != '0)
				model[w.r.rd] = res;
			exp_count++;
			pend_vals.push_back(res);
		end
		tab_inst.push_back(w);
		tab_exp.push_back(res);
	endtask

	task automatic build_alu_set();
		int rd;
		for (int r = 1; r <= 8; r++)     // ADDI / ORI loads from x0
			add_entry(i_word(rnd12(), 0, (r % 2 == 1) ? 3'd0 : 3'd6, r, OPC_OP_IMM));
		rd = 10;
		for (int f = 0; f < 8; f++) begin
			add_entry(r_word(7'h00, pick_src(), pick_src(), 3'(f), rd));
			rd++;
			if (f == 0 || f == 5) begin  // SUB and SRA
				add_entry(r_word(7'h20, pick_src(), pick_src(), 3'(f), rd));
				rd++;
			end
		end
		rd = 20;
		for (int f = 0; f < 8; f++) begin
			if (f != 1 && f != 5) begin
				add_entry(i_word(rnd12(), pick_src(), 3'(f), rd, OPC_OP_IMM));
				rd++;
			end
		end
		add_entry(i_word(rnd12() & 12'h01f, pick_src(), 3'd1, 26, OPC_OP_IMM));  // SLLI
		add_entry(i_word(rnd12() & 12'h01f, pick_src(), 3'd5, 27, OPC_OP_IMM));  // SRLI
		add_entry(i_word(12'h400 | (rnd12() & 12'h01f), pick_src(), 3'd5, 28,
			OPC_OP_IMM));                                             // SRAI
		for (int k = 0; k < 8; k++)      // Chain through x29 / x30
			add_entry(r_word(7'h00, (k % 3 == 0) ? 29 + ((k + 1) % 2) : pick_src(),
				(k == 0) ? 1 : 29 + ((k + 1) % 2), 3'(k), 29 + (k % 2)));
		add_entry(r_word(7'h00, 2, 1, 3'd0, 0));                    // ADD to x0
		add_entry(i_word(rnd12(), 3, 3'd6, 0, OPC_OP_IMM));         // ORI to x0
		add_entry(i_word(rnd12(), 1, 3'd2, 5, 7'b0000011));         // LW, not handled
		add_entry(i_word(rnd12(), 2, 3'd0, 6, 7'b0110111));         // LUI, not handled
	endtask

	task automatic build_burst();
		for (int k = 0; k < 6; k++)      // Long chain on x31
			add_entry(r_word(7'h00, pick_src(), 31, (k % 2 == 0) ? 3'd0 : 3'd4, 31));
		for (int k = 0; k < 5; k++)      // Five readers of the chain tail
			add_entry(r_word(7'h00, pick_src(), 31, 3'(k + 2), 10 + k));
	endtask

	// --------------------------------------------------
	// Drive, drain and compare
	// --------------------------------------------------
	task automatic read_reg(input int addr, output logic [XLEN-1:0] v, output logic [TAG_W-1:0] t);
		debug_addr = REG_ADDR_W'(addr);
		#0.1;
		{t, v} = debug_data;
	endtask

	// Entered at 1 ns after an edge, leaves 1 ns after the accepting edge
	task automatic present_inst(input inst_word_u w);
		int waited;
		inst       = w;
		inst_valid = 1'b1;
		waited     = 0;
		while (issue_stall) begin        // Hold while the pool is full
			waited++;
			if (waited > STALL_LIMIT)
				stop_run("timeout waiting for issue_stall to drop");
			@(posedge debug_clk);
			#1;
		end
		@(posedge debug_clk);
		#1;
	endtask

	task automatic apply_range(input int lo, input int hi);
		@(posedge debug_clk);
		#1;
		for (int idx = lo; idx < hi; idx++)
			present_inst(tab_inst[idx]);
		inst_valid = 1'b0;
	endtask

	task automatic drain_core();
		int               waited;
		logic             done;
		logic [XLEN-1:0]  v;
		logic [TAG_W-1:0] t;
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge debug_clk);
			#1;
			done = (cdb_count >= exp_count);
			for (int a = 0; a < NUM_REGS; a++) begin
				read_reg(a, v, t);
				if (t != '0)
					done = 1'b0;
			end
			waited++;
			if (!done && waited > DRAIN_LIMIT)
				stop_run("timeout waiting for the core to drain");
		end
	endtask

	task automatic verify_range(input int lo, input int hi);
		logic [XLEN-1:0]  v;
		logic [TAG_W-1:0] t;
		logic             last;
		@(posedge debug_clk);
		#1;
		for (int idx = lo; idx < hi; idx++) begin
			last = is_alu(tab_inst[idx]) && tab_inst[idx].r.rd != '0;
			for (int j = idx + 1; j < hi; j++)   // Only the final writer of rd
				if (is_alu(tab_inst[j]) && tab_inst[j].r.rd == tab_inst[idx].r.rd)
					last = 1'b0;
			if (last) begin
				read_reg(int'(tab_inst[idx].r.rd), v, t);
				check_reg(int'(tab_inst[idx].r.rd), v, t, tab_exp[idx]);
			end
		end
		for (int r = 0; r < NUM_REGS; r++) begin   // x0 and untouched regs too
			read_reg(r, v, t);
			check_reg(r, v, t, model[r]);
		end
	endtask

	initial begin
		int               lo;
		int               stall_before;
		logic [XLEN-1:0]  v;
		logic [TAG_W-1:0] t;
		rst         = 1'b1;
		inst_valid  = 1'b0;
		inst        = '0;
		debug_addr  = '0;
		exp_count   = 0;
		cdb_count   = 0;
		stall_count = 0;
		for (int r = 0; r < NUM_REGS; r++)
			model[r] = '0;
		repeat (4) @(posedge debug_clk);
		#1;
		rst = 1'b0;

		check_flag("cdb_valid", cdb_valid, 1'b0);
		check_flag("issue_stall", issue_stall, 1'b0);
		for (int r = 0; r < NUM_REGS; r++) begin
			read_reg(r, v, t);
			check_reg(r, v, t, '0);
		end

		lo = tab_inst.size();            // ALU ops, chains, x0, unsupported
		build_alu_set();
		apply_range(lo, tab_inst.size());
		drain_core();
		check_count("cdb_valid pulses", cdb_count, exp_count);
		verify_range(lo, tab_inst.size());

		lo           = tab_inst.size();  // Stall burst
		stall_before = stall_count;
		build_burst();
		apply_range(lo, tab_inst.size());
		drain_core();
		check_count("cdb_valid pulses", cdb_count, exp_count);
		check_flag("issue_stall seen in burst", stall_count > stall_before, 1'b1);
		verify_range(lo, tab_inst.size());

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
tomasulo_pkg.sv
alu_issue.sv
tagged_regfile.sv
alu_station.sv
alu_exec.sv
tomasulo_alu_core.sv
tb_tomasulo_alu_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_tomasulo_alu_core -Mdir obj_dir -f src.f

if ! out=$(./obj_dir/Vtb_tomasulo_alu_core 2>&1); then
	echo "$out"
	exit 1
fi
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
